// File: compile.f
+incdir+verilog
verilog/cpuCtrlPkg.sv
verilog/predecode.sv
verilog/interruptControl.sv
verilog/timingSequencer.sv
verilog/controlDecode.sv
verilog/cpuCtrl.sv
sim/cpuCtrl_props.sv
sim/cpuCtrlTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log.
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module cpuCtrlTb -o simv \
    > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "^\*\*\* PASSED \*\*\*$" sim.log && exit 0 || exit 1

// File: sim/cpuCtrlTb.sv
// Inputs change only at rising phi1 and outputs are checked at falling phi1 against a cycle model.
`default_nettype none

`include "cpuCtrl_consts.svh"

module cpuCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic phi1 = 1'b0;
    logic phi2 = 1'b1;
    logic [7:0] dataBus = 8'hEA;
    logic RDY = 1'b1;
    logic NMI_L = 1'b1;
    logic IRQ_L = 1'b1;
    logic RES_L = 1'b1;
    logic iFlag = 1'b1;
    logic sync;
    logic rw;
    logic [1:0] vecSel;
    logic [2:0] tState;
    cpuCtrlPkg::opcodeU opcode;
    logic [2:0] mT = `T1; // model state of the cycle that runs now.
    logic [7:0] mOp = 8'h00;
    logic [1:0] mKind = `INT_NONE;
    logic [1:0] pendKind = `INT_NONE; // interrupt the next fetch must take.
    int cycles = 0;

    cpuCtrl dut0 (.phi1(phi1), .phi2(phi2), .dataBus(dataBus), .RDY(RDY), .NMI_L(NMI_L),
        .IRQ_L(IRQ_L), .RES_L(RES_L), .iFlag(iFlag), .sync(sync), .rw(rw),
        .vecSel(vecSel), .tState(tState), .opcode(opcode));

    always #50 phi1 = ~phi1;

    task automatic stopWithFail();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkVal(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (exp === act) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stopWithFail();
        end
    endtask

    // the length is given as the number of the final T-state.
    function automatic logic [2:0] instLength(input logic [7:0] op);
        if (op == `OP_BRK) return `LEN_BRK;
        if (op[4:2] == 3'b010) return 3'd2; // immediate or implied.
        if (op[4:2] == 3'b001) return 3'd3; // zero page.
        if (op[1:0] != 2'b01 && op[4:2] == 3'b000 && op[7]) return 3'd2;
        return 3'd4;
    endfunction

    function automatic logic pickRdy(input bit randomRdy);
        if (randomRdy) return ($urandom % 3) != 0;
        return 1'b1;
    endfunction

    always @(negedge phi1) begin
        logic expRw;
        logic [1:0] expVec;
        logic isStore;
        if (!phi2) begin
            isStore = (mOp[7:5] == 3'b100) && (mOp[4:2] == 3'b001 || mOp[4:2] == 3'b011);
            expRw = !(isStore && mT == instLength(mOp));
            if (mOp == `OP_BRK && mT >= `T3 && mT <= `T5 && mKind != `INT_RES) expRw = 1'b0;
            expVec = `VEC_NONE;
            if (mOp == `OP_BRK && mT >= `T6) begin
                expVec = (mKind == `INT_NMI) ? `VEC_NMI :
                         (mKind == `INT_RES) ? `VEC_RES : `VEC_IRQ;
            end
            checkVal("tState", 8'(mT), 8'(tState));
            checkVal("sync", 8'(mT == `T1), 8'(sync));
            checkVal("rw", 8'(expRw), 8'(rw));
            checkVal("vecSel", 8'(expVec), 8'(vecSel));
            checkVal("opcode", mOp, opcode.raw);
            if (RDY || !expRw) begin // writes never stall.
                if (mT == `T1) begin
                    mOp = (pendKind != `INT_NONE) ? `OP_BRK : dataBus;
                    mKind = pendKind;
                    pendKind = `INT_NONE;
                end
                mT = (mT == instLength(mOp) && mT != `T1) ? `T1 : mT + 3'd1;
            end
        end
    end

    always @(posedge phi1) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("timeout: the tests did not finish within 4000 cycles");
            stopWithFail();
        end
    end

    // starts and ends on a rising edge where mT names the cycle that begins.
    task automatic runOp(input logic [7:0] op, input bit randomRdy);
        while (mT != `T1) @(posedge phi1);
        dataBus <= op;
        RDY <= pickRdy(randomRdy);
        @(posedge phi1);
        while (mT != `T2) begin
            RDY <= pickRdy(randomRdy);
            @(posedge phi1);
        end
        RDY <= pickRdy(randomRdy); // T2 is a read cycle and may stall too.
        @(negedge phi1);
        checkVal("opcode", op, opcode.raw);
        forever begin
            @(posedge phi1);
            if (mT == `T1) break;
            RDY <= pickRdy(randomRdy);
        end
        RDY <= 1'b1;
    endtask

    // holds the fetch for the three edges a request needs to reach activeInt.
    task automatic serviceInt(input logic [1:0] kind);
        while (mT != `T1) @(posedge phi1);
        RDY <= 1'b0;
        repeat (3) @(posedge phi1);
        pendKind = kind;
        RDY <= 1'b1;
        dataBus <= 8'hEA;
        if (kind == `INT_RES) RES_L <= 1'b1;
        if (kind == `INT_NMI) NMI_L <= 1'b1;
        if (kind == `INT_IRQ) IRQ_L <= 1'b1;
        @(posedge phi1);
        while (mT != `T1) @(posedge phi1);
    endtask

    task automatic lengthTests();
        runOp(8'hA9, 1'b0); // immediate.
        runOp(8'hA5, 1'b0);
        runOp(8'hAD, 1'b0);
        runOp(8'hEA, 1'b0);
        runOp(8'hA2, 1'b0);
        repeat (100) runOp(8'($urandom), 1'b0);
    endtask

    task automatic storeTests();
        runOp(8'h85, 1'b0);
        runOp(8'h8D, 1'b0);
        runOp(8'h86, 1'b0);
        runOp(8'h8E, 1'b0);
        runOp(8'hAD, 1'b0);
    endtask

    task automatic stallTests();
        runOp(8'hAD, 1'b1);
        repeat (4) runOp(8'h00, 1'b1); // BRK pushes run through RDY low.
        repeat (30) runOp(8'($urandom), 1'b1);
    endtask

    task automatic interruptTests();
        IRQ_L <= 1'b0; // masked while iFlag is high.
        repeat (4) runOp(8'hEA, 1'b0);
        IRQ_L <= 1'b1;
        repeat (3) runOp(8'hEA, 1'b0);
        iFlag <= 1'b0;
        IRQ_L <= 1'b0;
        serviceInt(`INT_IRQ);
        NMI_L <= 1'b0;
        serviceInt(`INT_NMI);
        RES_L <= 1'b0;
        serviceInt(`INT_RES);
        runOp(8'hEA, 1'b0);
    endtask

    task automatic priorityTests();
        RES_L <= 1'b0;
        NMI_L <= 1'b0;
        IRQ_L <= 1'b0;
        serviceInt(`INT_RES);
        serviceInt(`INT_NMI);
        serviceInt(`INT_IRQ);
        runOp(8'h00, 1'b0); // software BRK takes the IRQ vector.
        runOp(8'hEA, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hc36b1d96));
        repeat (8) @(posedge phi1);
        phi2 <= 1'b0;
        @(posedge phi1);
        lengthTests();
        storeTests();
        stallTests();
        interruptTests();
        priorityTests();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/cpuCtrl_props.sv
// Checks only the strobe relations at rising phi1 and is silent while phi2 holds reset.
`default_nettype none

`include "cpuCtrl_consts.svh"

module cpuCtrlProps (
    input logic       phi1,
    input logic       phi2,
    input logic       sync,
    input logic       rw,
    input logic [1:0] vecSel,
    input logic [2:0] tState,
    input logic [1:0] intKind,
    input logic [7:0] opRaw
);
    timeunit 1ns;
    timeprecision 1ps;

    syncInT1: assert property (@(posedge phi1) disable iff (phi2)
        sync |-> (tState == `T1)) else $error("sync high outside T1");

    vecInT6T7: assert property (@(posedge phi1) disable iff (phi2)
        (vecSel != `VEC_NONE) |-> ((tState == `T6) || (tState == `T7)))
        else $error("vecSel active outside T6 and T7");

    // a reset sequence turns its pushes into reads.
    resetNoWrite: assert property (@(posedge phi1) disable iff (phi2)
        ((intKind == `INT_RES) && (opRaw == `OP_BRK)) |-> rw)
        else $error("write cycle during a reset sequence");

endmodule

bind cpuCtrl cpuCtrlProps props0 (.phi1(phi1), .phi2(phi2), .sync(sync), .rw(rw),
    .vecSel(vecSel), .tState(tState), .intKind(intKind), .opRaw(opcode.raw));

`default_nettype wire

// File: verilog/controlDecode.sv
// Pure decode of the current state. Strobes repeat unchanged while the sequencer stalls.
`default_nettype none

`include "cpuCtrl_consts.svh"

module controlDecode (
    input  logic [2:0]         tState,
    input  cpuCtrlPkg::opcodeU opcode,
    input  logic [1:0]         intKind,
    input  logic               lastCycle,
    output logic               sync,
    output logic               rw,
    output logic [1:0]         vecSel
);

    logic isBrk;
    logic isStore;
    logic pushCycle;
    logic vecCycle;
    logic storeWrite;
    logic brkWrite;

    assign isBrk = (opcode.raw == `OP_BRK);

    // stores are aaa 100 in zero page or absolute form.
    assign isStore = (opcode.fields.aaa == 3'b100) &&
                     ((opcode.fields.bbb == 3'b001) || (opcode.fields.bbb == 3'b011));

    assign pushCycle = (tState == `T3) || (tState == `T4) || (tState == `T5);
    assign vecCycle = (tState == `T6) || (tState == `T7);

    assign sync = (tState == `T1);

    assign storeWrite = isStore && lastCycle; // the data goes out in the final cycle.

    // A reset sequence runs the same cycles but with the stack pushes turned into reads.
    assign brkWrite = isBrk && pushCycle && (intKind != `INT_RES);

    assign rw = ~(storeWrite | brkWrite);

    always_comb begin
        vecSel = `VEC_NONE;
        if (isBrk && vecCycle) begin
            case (intKind)
                `INT_NMI: vecSel = `VEC_NMI;
                `INT_RES: vecSel = `VEC_RES;
                default: vecSel = `VEC_IRQ; // software BRK shares the IRQ vector.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpuCtrl.sv
// All state moves on rising phi1. phi2 high resets everything, and the I flag comes from outside.
`default_nettype none

module cpuCtrl (
    input  logic               phi1,
    input  logic               phi2,
    input  logic [7:0]         dataBus,
    input  logic               RDY,
    input  logic               NMI_L,
    input  logic               IRQ_L,
    input  logic               RES_L,
    input  logic               iFlag,
    output logic               sync,
    output logic               rw,
    output logic [1:0]         vecSel,
    output logic [2:0]         tState,
    output cpuCtrlPkg::opcodeU opcode
);

    logic [1:0] activeInt;
    logic [1:0] intKind;
    logic fetchEnd;
    logic intDone;
    logic lastCycle;

    predecode u_predecode (.phi1(phi1), .phi2(phi2), .dataBus(dataBus), .fetchEnd(fetchEnd),
        .activeInt(activeInt), .opcode(opcode));

    interruptControl u_interruptControl (.phi1(phi1), .phi2(phi2), .NMI_L(NMI_L),
        .IRQ_L(IRQ_L), .RES_L(RES_L), .iFlag(iFlag), .intDone(intDone), .activeInt(activeInt));

    timingSequencer u_timingSequencer (.phi1(phi1), .phi2(phi2), .RDY(RDY), .opcode(opcode),
        .activeInt(activeInt), .rw(rw), .tState(tState), .intKind(intKind),
        .fetchEnd(fetchEnd), .intDone(intDone), .lastCycle(lastCycle));

    controlDecode u_controlDecode (.tState(tState), .opcode(opcode), .intKind(intKind),
        .lastCycle(lastCycle), .sync(sync), .rw(rw), .vecSel(vecSel));

endmodule

`default_nettype wire

// File: verilog/cpuCtrlPkg.sv
// Opcode view only. The aaa/bbb/cc split follows the usual 6502 grouping and carries no legality check.
`default_nettype none

package cpuCtrlPkg;

    // One opcode byte, read either as the raw value or split into its decode fields.
    // The raw view is used for loading and for the BRK compare.
    // The field view drives the length rule and the store decode.
    typedef union packed {
        logic [7:0] raw; // the byte as fetched.
        struct packed {
            logic [2:0] aaa; // operation within the group.
            logic [2:0] bbb; // addressing mode.
            logic [1:0] cc; // instruction group.
        } fields;
    } opcodeU;

endpackage

`default_nettype wire

// File: verilog/cpuCtrl_consts.svh
// Shared codes only. The vector codes select FFFA, FFFC and FFFE and are not addresses themselves.
`ifndef CPUCTRL_CONSTS_SVH
`define CPUCTRL_CONSTS_SVH

`define OP_BRK 8'h00 // software break, also forced in for a taken interrupt.

// interrupt kind carried by activeInt and intKind.
`define INT_NONE 2'd0
`define INT_IRQ 2'd1
`define INT_NMI 2'd2
`define INT_RES 2'd3

// vecSel codes, 0 means no vector fetch.
`define VEC_NONE 2'd0
`define VEC_NMI 2'd1 // FFFA.
`define VEC_RES 2'd2 // FFFC.
`define VEC_IRQ 2'd3 // FFFE, shared with software BRK.

// T-state numbers. T1 is always the opcode fetch.
`define T1 3'd1
`define T2 3'd2
`define T3 3'd3
`define T4 3'd4
`define T5 3'd5
`define T6 3'd6
`define T7 3'd7

`define LEN_BRK 3'd7 // BRK and every interrupt sequence.
`endif

// File: verilog/interruptControl.sv
// Lines are active low and idle high. A second NMI edge during NMI handling is merged with the first.
`default_nettype none

`include "cpuCtrl_consts.svh"

module interruptControl (
    input  logic       phi1,
    input  logic       phi2,
    input  logic       NMI_L,
    input  logic       IRQ_L,
    input  logic       RES_L,
    input  logic       iFlag,
    input  logic       intDone,
    output logic [1:0] activeInt
);

    logic nmiSync1;
    logic nmiSync2;
    logic nmiPrev;
    logic irqSync1;
    logic irqSync2;
    logic resSync1;
    logic resSync2;
    logic nmiLatch;
    logic nmiFall;
    logic pendNmi;
    logic pendIrq;
    logic pendRes;

    // two-flop synchronizers, reset to the idle level.
    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            nmiSync1 <= 1'b1;
            nmiSync2 <= 1'b1;
            nmiPrev <= 1'b1;
            irqSync1 <= 1'b1;
            irqSync2 <= 1'b1;
            resSync1 <= 1'b1;
            resSync2 <= 1'b1;
        end else begin
            nmiSync1 <= NMI_L;
            nmiSync2 <= nmiSync1;
            nmiPrev <= nmiSync2; // one cycle older copy for the edge detect.
            irqSync1 <= IRQ_L;
            irqSync2 <= irqSync1;
            resSync1 <= RES_L;
            resSync2 <= resSync1;
        end
    end

    assign nmiFall = nmiPrev & ~nmiSync2; // high for one cycle per falling edge.

    // NMI stays pending after the line goes back high.
    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            nmiLatch <= 1'b0;
        end else if (nmiFall) begin
            nmiLatch <= 1'b1; // a fresh edge beats a clear in the same cycle.
        end else if (intDone && (activeInt == `INT_NMI)) begin
            nmiLatch <= 1'b0;
        end
    end

    assign pendRes = ~resSync2;
    assign pendNmi = nmiLatch | nmiFall; // the edge counts in the cycle it is seen.
    assign pendIrq = ~irqSync2 & ~iFlag; // IRQ is masked by the I flag.

    // The priority register picks only when idle, so a request is held until its sequence ends.
    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            activeInt <= `INT_NONE;
        end else if (intDone) begin
            activeInt <= `INT_NONE;
        end else if (activeInt == `INT_NONE) begin
            if (pendRes) begin
                activeInt <= `INT_RES;
            end else if (pendNmi) begin
                activeInt <= `INT_NMI;
            end else if (pendIrq) begin
                activeInt <= `INT_IRQ;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/predecode.sv
// Loads only when the sequencer flags a fetch end. A pending interrupt always wins over the bus byte.
`default_nettype none

`include "cpuCtrl_consts.svh"

module predecode (
    input  logic               phi1,
    input  logic               phi2,
    input  logic [7:0]         dataBus,
    input  logic               fetchEnd,
    input  logic [1:0]         activeInt,
    output cpuCtrlPkg::opcodeU opcode
);

    logic takeInt;
    logic [7:0] nextOp;

    assign takeInt = (activeInt != `INT_NONE); // an interrupt is waiting at this fetch.

    // Substitute BRK so the interrupt runs through the normal break sequence.
    always_comb begin
        if (takeInt) begin
            nextOp = `OP_BRK;
        end else begin
            nextOp = dataBus;
        end
    end

    // instruction register, it holds through the whole instruction.
    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            opcode.raw <= `OP_BRK;
        end else if (fetchEnd) begin
            opcode.raw <= nextOp; // loads on the edge that ends T1.
        end
    end

endmodule

`default_nettype wire

// File: verilog/timingSequencer.sv
// Lengths are base counts only, with no index or page-crossing cycles. Opcodes with cc 11 use the cc 00/10 rule.
`default_nettype none

`include "cpuCtrl_consts.svh"

module timingSequencer (
    input  logic               phi1,
    input  logic               phi2,
    input  logic               RDY,
    input  cpuCtrlPkg::opcodeU opcode,
    input  logic [1:0]         activeInt,
    input  logic               rw,
    output logic [2:0]         tState,
    output logic [1:0]         intKind,
    output logic               fetchEnd,
    output logic               intDone,
    output logic               lastCycle
);

    logic [2:0] instLen;
    logic advance;

    // Instruction length equals the number of its final T-state.
    always_comb begin
        if (opcode.raw == `OP_BRK) begin
            instLen = `LEN_BRK;
        end else if (opcode.fields.cc == 2'b01) begin
            case (opcode.fields.bbb)
                3'b010: instLen = `T2; // immediate.
                3'b001: instLen = `T3; // zero page.
                default: instLen = `T4;
            endcase
        end else begin
            case (opcode.fields.bbb)
                3'b010: instLen = `T2; // implied or accumulator.
                3'b000: begin
                    // The upper half of the opcode map takes an immediate operand here.
                    if (opcode.fields.aaa[2]) begin
                        instLen = `T2;
                    end else begin
                        instLen = `T4;
                    end
                end
                3'b001: instLen = `T3;
                default: instLen = `T4;
            endcase
        end
    end

    // T1 is never final since every length is at least two.
    assign lastCycle = (tState == instLen);

    assign advance = RDY | ~rw; // write cycles ignore RDY.

    assign fetchEnd = (tState == `T1) && advance;

    // Only a BRK sequence reaches T7.
    assign intDone = (tState == `T7) && (intKind != `INT_NONE) && advance;

    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            tState <= `T1;
        end else if (advance) begin
            if (lastCycle) begin
                tState <= `T1;
            end else begin
                tState <= 3'(tState + 3'd1);
            end
        end
    end

    // The kind comes from the same edge that loads the opcode, so a software BRK stays none.
    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            intKind <= `INT_NONE;
        end else if (fetchEnd) begin
            intKind <= activeInt;
        end
    end

endmodule

`default_nettype wire
